/* hdl/lsu_defs.svh */
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// store queue entries
`define SB_DEPTH 8

// data memory size in 32-bit words
`define DMEM_WORDS 256

// cycles from request cycle to resp
`define DMEM_LATENCY 2

`endif

/* hdl/rv32i_types.sv */
package rv32i_types;

    // data word or byte address
    typedef logic [31:0] word_t;

    // byte enables, zero means no request
    typedef logic [3:0] mask_t;

    // load/store width code
    typedef logic [2:0] funct3_t;

    // request from the core pipeline
    typedef struct packed {
        logic    valid;
        logic    is_store;
        funct3_t funct3;
        word_t   addr;
        word_t   wdata;
    } lsu_req_t;

    // one store queue slot, all zero when free
    typedef struct packed {
        word_t addr;
        word_t data;
        mask_t mask;
        logic  sent_to_cache;
    } sb_info;

    typedef enum logic {
        DMEM_IDLE,
        DMEM_BUSY
    } dmem_state_t;

endpackage : rv32i_types

/* hdl/lsu_align.sv */
module lsu_align
import rv32i_types::*;
(
    input   lsu_req_t   req,
    input   word_t      load_data_raw,
    input   logic       load_resp_raw,
    input   logic       clk,
    input   logic       rst,
    output  word_t      store_addr,
    output  word_t      store_data,
    output  mask_t      store_mask,
    output  word_t      load_addr,
    output  mask_t      load_mask,
    output  word_t      load_data
);

    localparam funct3_t F3_B  = 3'b000;
    localparam funct3_t F3_H  = 3'b001;
    localparam funct3_t F3_BU = 3'b100;
    localparam funct3_t F3_HU = 3'b101;

    mask_t      req_mask;
    word_t      word_addr;
    word_t      lanes;
    logic [1:0] pend_offset;
    funct3_t    pend_funct3;
    logic       pend;

    assign word_addr = {req.addr[31:2], 2'b00};

    // byte enables from width and offset
    always_comb begin
        unique case (req.funct3)
            F3_B, F3_BU: req_mask = 4'b0001 << req.addr[1:0];
            F3_H, F3_HU: req_mask = 4'b0011 << req.addr[1:0];
            default:     req_mask = 4'b1111;
        endcase
    end

    assign store_addr = word_addr;
    assign store_mask = (req.valid && req.is_store) ? req_mask : '0;
    assign load_addr  = word_addr;
    assign load_mask  = (req.valid && !req.is_store) ? req_mask : '0;

    // replicate so every lane holds the value
    always_comb begin
        unique case (req.funct3)
            F3_B:    store_data = {4{req.wdata[7:0]}};
            F3_H:    store_data = {2{req.wdata[15:0]}};
            default: store_data = req.wdata;
        endcase
    end

    // remember how to format the outstanding load
    always_ff @(posedge clk) begin
        if (rst) begin
            pend <= 1'b0;
        end else if (load_mask != '0) begin
            pend <= 1'b1;
        end else if (load_resp_raw) begin
            pend <= 1'b0;
        end
        if (load_mask != '0) begin
            pend_offset <= req.addr[1:0];
            pend_funct3 <= req.funct3;
        end
    end

    assign lanes = load_data_raw >> {pend_offset, 3'b000};

    always_comb begin
        load_data = '0;
        if (load_resp_raw && pend) begin
            unique case (pend_funct3)
                F3_B:    load_data = {{24{lanes[7]}}, lanes[7:0]};
                F3_BU:   load_data = {24'b0, lanes[7:0]};
                F3_H:    load_data = {{16{lanes[15]}}, lanes[15:0]};
                F3_HU:   load_data = {16'b0, lanes[15:0]};
                default: load_data = load_data_raw;
            endcase
        end
    end

endmodule : lsu_align

/* hdl/store_buffer.sv */
`include "lsu_defs.svh"

module store_buffer
import rv32i_types::*;
(
    input   logic   clk,
    input   logic   rst,

    // aligned requests from the core side
    input   word_t  store_data,
    input   word_t  store_addr,
    input   word_t  load_addr,
    input   mask_t  store_mask,
    input   mask_t  load_mask,

    // memory response
    input   logic   ufp_resp,
    input   word_t  ufp_rdata,

    output  logic   full,
    output  word_t  load_data,
    output  logic   load_resp,
    output  logic   store_resp,

    // memory request
    output  word_t  sb_ufp_addr,
    output  word_t  sb_ufp_wdata,
    output  mask_t  sb_ufp_rmask,
    output  mask_t  sb_ufp_wmask
);

    localparam int IDX_W = $clog2(`SB_DEPTH);

    sb_info             buf_q [`SB_DEPTH];
    sb_info             buf_d [`SB_DEPTH];
    word_t              load_addr_q, load_addr_d;
    mask_t              load_mask_q, load_mask_d;
    logic               load_new_q;
    logic               read_out_q, read_out_d;
    logic               hit;
    logic   [IDX_W-1:0] hit_idx;
    logic               slot_found;
    logic   [IDX_W-1:0] slot_idx;
    logic               q_empty;
    logic               dequeue;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `SB_DEPTH; i++) begin
                buf_q[i] <= '0;
            end
            load_addr_q <= '0;
            load_mask_q <= '0;
            load_new_q  <= 1'b0;
            read_out_q  <= 1'b0;
            store_resp  <= 1'b0;
        end else begin
            buf_q       <= buf_d;
            load_addr_q <= load_addr_d;
            load_mask_q <= load_mask_d;
            load_new_q  <= (load_mask != '0);
            read_out_q  <= read_out_d;
            store_resp  <= (store_mask != '0);
        end
    end

    always_comb begin
        buf_d        = buf_q;
        load_addr_d  = load_addr_q;
        load_mask_d  = load_mask_q;
        read_out_d   = read_out_q;
        load_data    = '0;
        load_resp    = 1'b0;
        sb_ufp_addr  = '0;
        sb_ufp_wdata = '0;
        sb_ufp_rmask = '0;
        sb_ufp_wmask = '0;
        hit          = 1'b0;
        hit_idx      = '0;
        slot_found   = 1'b0;
        slot_idx     = '0;

        q_empty = (buf_q[0] == '0);
        dequeue = buf_q[0].sent_to_cache && ufp_resp;
        full    = (buf_q[`SB_DEPTH-1] != '0) && !dequeue;

        // only a freshly registered load may forward; later hits
        // would come from stores younger than the load
        if (load_new_q) begin
            for (int i = 0; i < `SB_DEPTH; i++) begin
                if (buf_q[i].addr == load_addr_q && buf_q[i].mask == load_mask_q) begin
                    hit     = 1'b1;
                    hit_idx = IDX_W'(i);
                end
            end
        end

        if (hit) begin
            load_data   = buf_q[hit_idx].data;
            load_resp   = 1'b1;
            load_addr_d = '0;
            load_mask_d = '0;
        end

        if (read_out_q && ufp_resp) begin
            load_data  = ufp_rdata;
            load_resp  = 1'b1;
            read_out_d = 1'b0;
        end

        if (dequeue) begin
            for (int i = 0; i < `SB_DEPTH - 1; i++) begin
                buf_d[i] = buf_q[i+1];
            end
            buf_d[`SB_DEPTH-1] = '0;
        end else if (!q_empty && !buf_q[0].sent_to_cache && !read_out_q) begin
            // head goes out once
            sb_ufp_addr            = buf_q[0].addr;
            sb_ufp_wdata           = buf_q[0].data;
            sb_ufp_wmask           = buf_q[0].mask;
            buf_d[0].sent_to_cache = 1'b1;
        end else if (q_empty && load_mask_q != '0 && !hit && !read_out_q) begin
            sb_ufp_addr  = load_addr_q;
            sb_ufp_rmask = load_mask_q;
            read_out_d   = 1'b1;
            load_addr_d  = '0;
            load_mask_d  = '0;
        end

        if (load_mask != '0) begin
            load_addr_d = load_addr;
            load_mask_d = load_mask;
        end

        // append at the first free slot after any shift
        for (int i = 0; i < `SB_DEPTH; i++) begin
            if (!slot_found && buf_d[i] == '0) begin
                slot_found = 1'b1;
                slot_idx   = IDX_W'(i);
            end
        end

        if (store_mask != '0 && slot_found) begin
            buf_d[slot_idx] = '{addr: store_addr, data: store_data,
                                mask: store_mask, sent_to_cache: 1'b0};
        end
    end

endmodule : store_buffer

/* hdl/data_memory.sv */
`include "lsu_defs.svh"

module data_memory
import rv32i_types::*;
(
    input   logic   clk,
    input   logic   rst,
    input   word_t  addr,
    input   mask_t  rmask,
    input   mask_t  wmask,
    input   word_t  wdata,
    output  logic   resp,
    output  word_t  rdata
);

    localparam int AW    = $clog2(`DMEM_WORDS);
    localparam int CNT_W = $clog2(`DMEM_LATENCY + 1);

    word_t              mem [`DMEM_WORDS];
    dmem_state_t        state;
    logic   [CNT_W-1:0] cnt;
    logic   [AW-1:0]    idx_q;
    mask_t              wmask_q;
    word_t              wdata_q;
    logic               done;

    // known contents for the testbench model
    initial begin
        for (int i = 0; i < `DMEM_WORDS; i++) begin
            mem[i] = word_t'(i) * 32'h0101_0101;
        end
    end

    assign done = (state == DMEM_BUSY) && (cnt == CNT_W'(`DMEM_LATENCY - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= DMEM_IDLE;
            cnt   <= '0;
        end else begin
            unique case (state)
                DMEM_IDLE: begin
                    if (rmask != '0 || wmask != '0) begin
                        state <= DMEM_BUSY;
                        cnt   <= '0;
                    end
                end
                DMEM_BUSY: begin
                    if (done) begin
                        state <= DMEM_IDLE;
                    end
                    cnt <= cnt + 1'b1;
                end
                default: state <= DMEM_IDLE;
            endcase
        end
    end

    // capture request while idle
    always_ff @(posedge clk) begin
        if (state == DMEM_IDLE) begin
            idx_q   <= addr[AW+1:2];
            wmask_q <= wmask;
            wdata_q <= wdata;
        end
        if (done) begin
            for (int b = 0; b < 4; b++) begin
                if (wmask_q[b]) begin
                    mem[idx_q][8*b +: 8] <= wdata_q[8*b +: 8];
                end
            end
        end
    end

    assign resp  = done;
    assign rdata = done ? mem[idx_q] : '0;

endmodule : data_memory

/* hdl/lsu_top.sv */
module lsu_top
import rv32i_types::*;
(
    input   logic       clk,
    input   logic       rst,
    input   lsu_req_t   req,
    output  logic       full,
    output  word_t      load_data,
    output  logic       load_resp,
    output  logic       store_resp
);

    word_t  store_addr, store_data, load_addr;
    mask_t  store_mask, load_mask;
    word_t  load_data_raw;
    word_t  sb_ufp_addr, sb_ufp_wdata, ufp_rdata;
    mask_t  sb_ufp_rmask, sb_ufp_wmask;
    logic   ufp_resp;

    lsu_align u_align (
        .req           (req),
        .load_data_raw (load_data_raw),
        .load_resp_raw (load_resp),
        .clk           (clk),
        .rst           (rst),
        .store_addr    (store_addr),
        .store_data    (store_data),
        .store_mask    (store_mask),
        .load_addr     (load_addr),
        .load_mask     (load_mask),
        .load_data     (load_data)
    );

    store_buffer u_sb (
        .clk          (clk),
        .rst          (rst),
        .store_data   (store_data),
        .store_addr   (store_addr),
        .load_addr    (load_addr),
        .store_mask   (store_mask),
        .load_mask    (load_mask),
        .ufp_resp     (ufp_resp),
        .ufp_rdata    (ufp_rdata),
        .full         (full),
        .load_data    (load_data_raw),
        .load_resp    (load_resp),
        .store_resp   (store_resp),
        .sb_ufp_addr  (sb_ufp_addr),
        .sb_ufp_wdata (sb_ufp_wdata),
        .sb_ufp_rmask (sb_ufp_rmask),
        .sb_ufp_wmask (sb_ufp_wmask)
    );

    data_memory u_dmem (
        .clk   (clk),
        .rst   (rst),
        .addr  (sb_ufp_addr),
        .rmask (sb_ufp_rmask),
        .wmask (sb_ufp_wmask),
        .wdata (sb_ufp_wdata),
        .resp  (ufp_resp),
        .rdata (ufp_rdata)
    );

endmodule : lsu_top

/* verification/lsu_tb.sv */
`include "lsu_defs.svh"

module lsu_tb
import rv32i_types::*;
();

    localparam funct3_t F3_B  = 3'b000;
    localparam funct3_t F3_H  = 3'b001;
    localparam funct3_t F3_W  = 3'b010;
    localparam funct3_t F3_BU = 3'b100;
    localparam funct3_t F3_HU = 3'b101;

    // about 70 requests, each at worst waiting out a full queue drain
    // of SB_DEPTH * (DMEM_LATENCY + 1) cycles, plus margin
    localparam int MAX_CYCLES = 4000;

    logic       clk;
    logic       rst;
    lsu_req_t   req;
    logic       full;
    word_t      load_data;
    logic       load_resp;
    logic       store_resp;

    logic       store_req;
    logic       fwd_load;
    logic       seen_req;
    logic       saw_full;
    int         errors;
    int         cycles;
    integer     seed;
    logic [7:0] model [`DMEM_WORDS*4];

    lsu_top dut (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .full       (full),
        .load_data  (load_data),
        .load_resp  (load_resp),
        .store_resp (store_resp)
    );

    assign store_req = req.valid && req.is_store;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst) begin
            seen_req <= 1'b0;
        end else if (req.valid) begin
            seen_req <= 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run still going after %0d cycles, %0d errors", cycles, errors);
            $display("Test failed");
            $finish;
        end
    end

    // store_resp follows every store by exactly one cycle
    assert property (@(posedge clk) disable iff (rst) store_resp == $past(store_req))
    else begin
        errors++;
        $display("store_resp does not match a store one cycle earlier");
    end

    assert property (@(posedge clk) disable iff (rst) fwd_load |=> load_resp)
    else begin
        errors++;
        $display("forwarded load did not respond one cycle after it was presented");
    end

    // the last slot only fills from a store appended the cycle before
    assert property (@(posedge clk) disable iff (rst) $rose(full) |-> $past(store_req))
    else begin
        errors++;
        $display("full went high without a store in the cycle before");
    end

    // quiet outputs until the first request
    assert property (@(posedge clk) disable iff (rst)
        !seen_req |-> !full && !load_resp && !store_resp)
    else begin
        errors++;
        $display("an output went high before any request was made");
    end

    function automatic void update_model(funct3_t f3, word_t addr, word_t data);
        int n;
        n = (f3 == F3_B) ? 1 : (f3 == F3_H) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            model[addr + i] = data[8*i +: 8];
        end
    endfunction

    function automatic word_t expected_load(funct3_t f3, word_t addr);
        case (f3)
            F3_B:    return {{24{model[addr][7]}}, model[addr]};
            F3_BU:   return {24'b0, model[addr]};
            F3_H:    return {{16{model[addr+1][7]}}, model[addr+1], model[addr]};
            F3_HU:   return {16'b0, model[addr+1], model[addr]};
            default: return {model[addr+3], model[addr+2], model[addr+1], model[addr]};
        endcase
    endfunction

    function automatic word_t pick_addr();
        return word_t'(($unsigned($random(seed)) % `DMEM_WORDS) * 4);
    endfunction

    // holds off while full, presents one store for one cycle
    task automatic send_store(input funct3_t f3, input word_t addr, input word_t data);
        while (full) begin
            saw_full = 1'b1;
            @(posedge clk);
            #2;
        end
        req = '{valid: 1'b1, is_store: 1'b1, funct3: f3, addr: addr, wdata: data};
        update_model(f3, addr, data);
        @(posedge clk);
        #2;
        req = '0;
    endtask

    task automatic run_load(input funct3_t f3, input word_t addr, input string name);
        word_t exp;
        exp = expected_load(f3, addr);
        req = '{valid: 1'b1, is_store: 1'b0, funct3: f3, addr: addr, wdata: '0};
        @(posedge clk);
        #2;
        req = '0;
        fwd_load = 1'b0;
        @(negedge clk);
        while (!load_resp) begin
            @(negedge clk);
        end
        assert (load_data == exp)
        else begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, load_data);
        end
        @(posedge clk);
        #2;
    endtask

    initial begin
        word_t a;
        word_t d;
        int    base;

        seed     = 38;
        errors   = 0;
        cycles   = 0;
        saw_full = 1'b0;
        fwd_load = 1'b0;
        req      = '0;
        rst      = 1'b1;
        for (int i = 0; i < `DMEM_WORDS*4; i++) begin
            model[i] = 8'(i >> 2);
        end
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        repeat (3) begin
            @(posedge clk);
            #2;
        end

        // word store then same-address word load, forwarded
        a = pick_addr();
        send_store(F3_W, a, $random(seed));
        fwd_load = 1'b1;
        run_load(F3_W, a, "forward");

        // byte and half stores merged in memory, read after the drain
        a = (a + 4) % (`DMEM_WORDS * 4);
        send_store(F3_B, a, $random(seed));
        send_store(F3_B, a + 1, $random(seed));
        send_store(F3_H, a + 2, $random(seed));
        run_load(F3_W, a, "merge lw");
        run_load(F3_HU, a + 2, "merge lhu");

        // sign and zero extension at every legal offset
        a = pick_addr();
        d = $random(seed);
        for (int k = 0; k < 2; k++) begin
            send_store(F3_W, a, (k == 0) ? d : ~d);
            for (int o = 0; o < 4; o++) begin
                run_load(F3_B, a + o, $sformatf("lb off %0d", o));
                run_load(F3_BU, a + o, $sformatf("lbu off %0d", o));
                if (o % 2 == 0) begin
                    run_load(F3_H, a + o, $sformatf("lh off %0d", o));
                    run_load(F3_HU, a + o, $sformatf("lhu off %0d", o));
                end
            end
        end

        // back-to-back stores until the queue fills, then read all back
        base = $unsigned($random(seed)) % `DMEM_WORDS;
        for (int i = 0; i < 2*`SB_DEPTH; i++) begin
            send_store(F3_W, word_t'(((base + i) % `DMEM_WORDS) * 4), $random(seed));
        end
        assert (saw_full)
        else begin
            errors++;
            $display("full never went high during the store burst");
        end
        for (int i = 0; i < 2*`SB_DEPTH; i++) begin
            run_load(F3_W, word_t'(((base + i) % `DMEM_WORDS) * 4),
                     $sformatf("burst word %0d", i));
        end

        repeat (2) @(posedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : lsu_tb

/* all.f */
+incdir+hdl
hdl/rv32i_types.sv
hdl/lsu_align.sv
hdl/store_buffer.sv
hdl/data_memory.sv
hdl/lsu_top.sv
verification/lsu_tb.sv
